// File: design/gpio_pkg.sv
package gpio_pkg;

   // ------------------------------
   // sizes
   // ------------------------------
   localparam int IO_NUM = 32;
   localparam int APB_DW = 32;
   localparam int APB_AW = 8;

   // ------------------------------
   // register map
   // ------------------------------
   // word addresses below this select a per-pin config byte
   localparam logic [APB_AW-1:0] ADDR_CFG_LIMIT = 8'h80;
   localparam logic [APB_AW-1:0] ADDR_INT_STAT  = 8'h80;
   localparam logic [APB_AW-1:0] ADDR_GPIN      = 8'h90;
   localparam logic [APB_AW-1:0] ADDR_GPOUT     = 8'hA0;

   // ------------------------------
   // config byte fields
   // ------------------------------
   localparam int CFG_OUT_EN   = 0;
   localparam int CFG_IN_EN    = 1;
   localparam int CFG_OE_EN    = 2;
   localparam int CFG_INT_EN   = 3;
   // low end of the 3-bit mode field, bits 7:5
   localparam int CFG_MODE_LSB = 5;

   typedef logic [7:0] cfg_t;

   // 5 and 6 are not listed and act as disabled
   typedef enum logic [2:0] {
      MODE_LEVEL_HIGH = 3'd0,
      MODE_LEVEL_LOW  = 3'd1,
      MODE_EDGE_POS   = 3'd2,
      MODE_EDGE_NEG   = 3'd3,
      MODE_EDGE_BOTH  = 3'd4,
      MODE_DISABLED   = 3'd7
   } int_mode_t;

   // one bit per pin
   typedef logic [IO_NUM-1:0] pin_vec_t;

endpackage

// File: design/gpio_apb_regs.sv
`timescale 1ns/1ps

module gpio_apb_regs (
   input  logic                              PCLK,
   input  logic                              aresetn,
   input  logic                              psel_i,
   input  logic                              penable_i,
   input  logic                              pwrite_i,
   input  logic [gpio_pkg::APB_AW-1:0]       paddr_i,
   input  logic [gpio_pkg::APB_DW-1:0]       pwdata_i,
   input  gpio_pkg::pin_vec_t                gpin_sync_i,
   input  gpio_pkg::pin_vec_t                int_stat_i,
   output logic [gpio_pkg::APB_DW-1:0]       prdata_o,
   output gpio_pkg::pin_vec_t                gpio_out_o,
   output gpio_pkg::pin_vec_t                gpio_oe_o,
   output gpio_pkg::pin_vec_t                int_en_o,
   output gpio_pkg::int_mode_t               int_mode_o [gpio_pkg::IO_NUM],
   output gpio_pkg::pin_vec_t                clr_mask_o
);

   gpio_pkg::cfg_t                           cfg_q [gpio_pkg::IO_NUM];
   gpio_pkg::pin_vec_t                       gpout_q;
   gpio_pkg::pin_vec_t                       gpin_gated;
   logic [$clog2(gpio_pkg::IO_NUM)-1:0]      cfg_idx;
   logic                                     wr_en;
   logic                                     wr_cfg;
   logic                                     wr_stat;
   logic                                     wr_gpout;

   // ------------------------------
   // write decode
   // ------------------------------
   assign wr_en    = psel_i & penable_i & pwrite_i;
   assign cfg_idx  = paddr_i[2 +: $clog2(gpio_pkg::IO_NUM)];
   assign wr_cfg   = wr_en && (paddr_i < gpio_pkg::ADDR_CFG_LIMIT);
   assign wr_stat  = wr_en && (paddr_i == gpio_pkg::ADDR_INT_STAT);
   assign wr_gpout = wr_en && (paddr_i == gpio_pkg::ADDR_GPOUT);

   // write-one-to-clear pulse, only during the status write
   assign clr_mask_o = wr_stat ? pwdata_i[gpio_pkg::IO_NUM-1:0] : '0;

   // ------------------------------
   // registers
   // ------------------------------
   // one config byte per pin, lower byte lane only
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         for (int i = 0; i < gpio_pkg::IO_NUM; i++)
         begin
            cfg_q[i] <= '0;
         end
      end
      else if (wr_cfg)
      begin
         cfg_q[cfg_idx] <= pwdata_i[$bits(gpio_pkg::cfg_t)-1:0];
      end
   end

   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         gpout_q <= '0;
      end
      else if (wr_gpout)
      begin
         gpout_q <= pwdata_i[gpio_pkg::IO_NUM-1:0];
      end
   end

   // ------------------------------
   // per-pin gating
   // ------------------------------
   for (genvar i = 0; i < gpio_pkg::IO_NUM; i++)
   begin : g_pin
      assign gpio_out_o[i] = gpout_q[i] & cfg_q[i][gpio_pkg::CFG_OUT_EN];
      // driver only on when the output path is enabled too
      assign gpio_oe_o[i]  = cfg_q[i][gpio_pkg::CFG_OE_EN] & cfg_q[i][gpio_pkg::CFG_OUT_EN];
      assign gpin_gated[i] = gpin_sync_i[i] & cfg_q[i][gpio_pkg::CFG_IN_EN];
      assign int_en_o[i]   = cfg_q[i][gpio_pkg::CFG_INT_EN];
      assign int_mode_o[i] = gpio_pkg::int_mode_t'(
         cfg_q[i][gpio_pkg::CFG_MODE_LSB +: $bits(gpio_pkg::int_mode_t)]);
   end

   // ------------------------------
   // read mux
   // ------------------------------
   // zero wait states, data straight from the address
   always_comb
   begin
      prdata_o = '0;
      if (paddr_i < gpio_pkg::ADDR_CFG_LIMIT)
      begin
         prdata_o[$bits(gpio_pkg::cfg_t)-1:0] = cfg_q[cfg_idx];
      end
      else if (paddr_i == gpio_pkg::ADDR_INT_STAT)
      begin
         prdata_o = int_stat_i;
      end
      else if (paddr_i == gpio_pkg::ADDR_GPIN)
      begin
         prdata_o = gpin_gated;
      end
      else if (paddr_i == gpio_pkg::ADDR_GPOUT)
      begin
         prdata_o = gpout_q;
      end
   end

endmodule

// File: design/gpio_in_sync.sv
`timescale 1ns/1ps

module gpio_in_sync (
   input  logic                 PCLK,
   input  logic                 aresetn,
   input  gpio_pkg::pin_vec_t   gpio_in_i,
   output gpio_pkg::pin_vec_t   sync_cur_o,
   output gpio_pkg::pin_vec_t   sync_prev_o
);

   gpio_pkg::pin_vec_t meta_q;
   gpio_pkg::pin_vec_t sync_q;
   gpio_pkg::pin_vec_t hist_q;

   // two-flop metastability chain, then one history stage
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         meta_q <= '0;
         sync_q <= '0;
         hist_q <= '0;
      end
      else
      begin
         meta_q <= gpio_in_i;
         sync_q <= meta_q;
         hist_q <= sync_q;
      end
   end

   // newest safe sample (edge 2) and the one before it (edge 3)
   assign sync_cur_o  = sync_q;
   assign sync_prev_o = hist_q;

endmodule

// File: design/gpio_edge_detect.sv
`timescale 1ns/1ps

module gpio_edge_detect (
   input  logic                 PCLK,
   input  logic                 aresetn,
   input  gpio_pkg::pin_vec_t   sync_cur_i,
   input  gpio_pkg::pin_vec_t   sync_prev_i,
   input  gpio_pkg::pin_vec_t   int_en_i,
   input  gpio_pkg::pin_vec_t   clr_mask_i,
   output gpio_pkg::pin_vec_t   edge_pos_o,
   output gpio_pkg::pin_vec_t   edge_neg_o,
   output gpio_pkg::pin_vec_t   edge_both_o
);

   gpio_pkg::pin_vec_t set_pos;
   gpio_pkg::pin_vec_t set_neg;
   gpio_pkg::pin_vec_t set_both;

   // next value of a sticky flag vector
   // a new edge beats a clear in the same cycle
   function automatic gpio_pkg::pin_vec_t sticky_next(
      input gpio_pkg::pin_vec_t flag,
      input gpio_pkg::pin_vec_t set,
      input gpio_pkg::pin_vec_t clr,
      input gpio_pkg::pin_vec_t en
   );
      return en & (set | (flag & ~clr));
   endfunction

   // ------------------------------
   // edge terms
   // ------------------------------
   assign set_pos  =  sync_cur_i & ~sync_prev_i;
   assign set_neg  = ~sync_cur_i &  sync_prev_i;
   assign set_both =  sync_cur_i ^  sync_prev_i;

   // flags stay at zero while the pin interrupt is off
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         edge_pos_o  <= '0;
         edge_neg_o  <= '0;
         edge_both_o <= '0;
      end
      else
      begin
         edge_pos_o  <= sticky_next(edge_pos_o, set_pos, clr_mask_i, int_en_i);
         edge_neg_o  <= sticky_next(edge_neg_o, set_neg, clr_mask_i, int_en_i);
         edge_both_o <= sticky_next(edge_both_o, set_both, clr_mask_i, int_en_i);
      end
   end

endmodule

// File: design/gpio_irq_gen.sv
`timescale 1ns/1ps

module gpio_irq_gen (
   input  logic                 PCLK,
   input  logic                 aresetn,
   input  gpio_pkg::pin_vec_t   sync_cur_i,
   input  gpio_pkg::pin_vec_t   edge_pos_i,
   input  gpio_pkg::pin_vec_t   edge_neg_i,
   input  gpio_pkg::pin_vec_t   edge_both_i,
   input  gpio_pkg::pin_vec_t   int_en_i,
   input  gpio_pkg::int_mode_t  int_mode_i [gpio_pkg::IO_NUM],
   input  gpio_pkg::pin_vec_t   clr_mask_i,
   output gpio_pkg::pin_vec_t   int_o,
   output logic                 int_or_o,
   output gpio_pkg::pin_vec_t   int_stat_o
);

   gpio_pkg::pin_vec_t int_src;

   // ------------------------------
   // source select per pin
   // ------------------------------
   for (genvar i = 0; i < gpio_pkg::IO_NUM; i++)
   begin : g_src
      always_comb
      begin
         case (int_mode_i[i])
            gpio_pkg::MODE_LEVEL_HIGH: int_src[i] = sync_cur_i[i];
            gpio_pkg::MODE_LEVEL_LOW:  int_src[i] = ~sync_cur_i[i];
            gpio_pkg::MODE_EDGE_POS:   int_src[i] = edge_pos_i[i];
            gpio_pkg::MODE_EDGE_NEG:   int_src[i] = edge_neg_i[i];
            gpio_pkg::MODE_EDGE_BOTH:  int_src[i] = edge_both_i[i];
            gpio_pkg::MODE_DISABLED:   int_src[i] = 1'b0;
            default:                   int_src[i] = 1'b0;
         endcase
      end
   end

   assign int_o    = int_src & int_en_i;
   assign int_or_o = |int_o;

   // ------------------------------
   // latched status
   // ------------------------------
   // follows INT one cycle late, except in the clear cycle
   // where written ones drop out of the held value
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         int_stat_o <= '0;
      end
      else if (|clr_mask_i)
      begin
         int_stat_o <= int_stat_o & ~clr_mask_i;
      end
      else
      begin
         int_stat_o <= int_o;
      end
   end

endmodule

// File: design/gpio_top.sv
`timescale 1ns/1ps

module gpio_top (
   input  logic                           PCLK,
   input  logic                           aresetn,
   // APB slave
   input  logic                           psel_i,
   input  logic                           penable_i,
   input  logic                           pwrite_i,
   input  logic [gpio_pkg::APB_AW-1:0]    paddr_i,
   input  logic [gpio_pkg::APB_DW-1:0]    pwdata_i,
   output logic [gpio_pkg::APB_DW-1:0]    prdata_o,
   output logic                           pready_o,
   output logic                           pslverr_o,
   // pins
   input  gpio_pkg::pin_vec_t             gpio_in_i,
   output gpio_pkg::pin_vec_t             gpio_out_o,
   output gpio_pkg::pin_vec_t             gpio_oe_o,
   // interrupts
   output gpio_pkg::pin_vec_t             int_o,
   output logic                           int_or_o
);

   gpio_pkg::pin_vec_t     sync_cur;
   gpio_pkg::pin_vec_t     sync_prev;
   gpio_pkg::pin_vec_t     edge_pos;
   gpio_pkg::pin_vec_t     edge_neg;
   gpio_pkg::pin_vec_t     edge_both;
   gpio_pkg::pin_vec_t     int_en;
   gpio_pkg::pin_vec_t     clr_mask;
   gpio_pkg::pin_vec_t     int_stat;
   gpio_pkg::int_mode_t    int_mode [gpio_pkg::IO_NUM];

   // no wait states and no error responses
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   // ------------------------------
   // register block
   // ------------------------------
   // levels and input reads use the history flop,
   // so they land on the same edge as the edge flags
   gpio_apb_regs u_regs (
      .PCLK        (PCLK),
      .aresetn     (aresetn),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .gpin_sync_i (sync_prev),
      .int_stat_i  (int_stat),
      .prdata_o    (prdata_o),
      .gpio_out_o  (gpio_out_o),
      .gpio_oe_o   (gpio_oe_o),
      .int_en_o    (int_en),
      .int_mode_o  (int_mode),
      .clr_mask_o  (clr_mask)
   );

   // ------------------------------
   // input pipeline
   // ------------------------------
   gpio_in_sync u_sync (
      .PCLK        (PCLK),
      .aresetn     (aresetn),
      .gpio_in_i   (gpio_in_i),
      .sync_cur_o  (sync_cur),
      .sync_prev_o (sync_prev)
   );

   gpio_edge_detect u_edge (
      .PCLK        (PCLK),
      .aresetn     (aresetn),
      .sync_cur_i  (sync_cur),
      .sync_prev_i (sync_prev),
      .int_en_i    (int_en),
      .clr_mask_i  (clr_mask),
      .edge_pos_o  (edge_pos),
      .edge_neg_o  (edge_neg),
      .edge_both_o (edge_both)
   );

   gpio_irq_gen u_irq (
      .PCLK        (PCLK),
      .aresetn     (aresetn),
      .sync_cur_i  (sync_prev),
      .edge_pos_i  (edge_pos),
      .edge_neg_i  (edge_neg),
      .edge_both_i (edge_both),
      .int_en_i    (int_en),
      .int_mode_i  (int_mode),
      .clr_mask_i  (clr_mask),
      .int_o       (int_o),
      .int_or_o    (int_or_o),
      .int_stat_o  (int_stat)
   );

endmodule

// File: tests/tb_gpio.sv
`timescale 1ns/1ps

module tb_gpio;

   localparam int CLK_PERIOD = 20;
   localparam int WAIT_LIMIT = 16;

   logic                          PCLK;
   logic                          aresetn;
   logic                          psel;
   logic                          penable;
   logic                          pwrite;
   logic [gpio_pkg::APB_AW-1:0]   paddr;
   logic [gpio_pkg::APB_DW-1:0]   pwdata;
   logic [gpio_pkg::APB_DW-1:0]   prdata;
   logic                          pready;
   logic                          pslverr;
   gpio_pkg::pin_vec_t            gpio_in;
   gpio_pkg::pin_vec_t            gpio_out;
   gpio_pkg::pin_vec_t            gpio_oe;
   gpio_pkg::pin_vec_t            int_vec;
   logic                          int_or;

   // reference model state
   logic [7:0]                    m_cfg [gpio_pkg::IO_NUM];
   gpio_pkg::pin_vec_t            m_gpout;
   gpio_pkg::pin_vec_t            m_h0;
   gpio_pkg::pin_vec_t            m_h1;
   gpio_pkg::pin_vec_t            m_h2;
   gpio_pkg::pin_vec_t            m_pos;
   gpio_pkg::pin_vec_t            m_neg;
   gpio_pkg::pin_vec_t            m_both;
   gpio_pkg::pin_vec_t            m_stat;

   logic [31:0]                   lfsr;
   int                            errors;
   int                            n_checks;

   gpio_top u_dut (
      .PCLK      (PCLK),
      .aresetn   (aresetn),
      .psel_i    (psel),
      .penable_i (penable),
      .pwrite_i  (pwrite),
      .paddr_i   (paddr),
      .pwdata_i  (pwdata),
      .prdata_o  (prdata),
      .pready_o  (pready),
      .pslverr_o (pslverr),
      .gpio_in_i (gpio_in),
      .gpio_out_o(gpio_out),
      .gpio_oe_o (gpio_oe),
      .int_o     (int_vec),
      .int_or_o  (int_or)
   );

   initial
   begin
      PCLK = 1'b0;
      forever #(CLK_PERIOD / 2) PCLK = ~PCLK;
   end

   // ------------------------------
   // helpers
   // ------------------------------
   // Galois form for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // per-pin interrupt as the mode and enable fields define it
   function automatic gpio_pkg::pin_vec_t model_int();
      gpio_pkg::pin_vec_t r;
      r = '0;
      for (int i = 0; i < gpio_pkg::IO_NUM; i++)
      begin
         case (m_cfg[i][7:5])
            3'd0:    r[i] = m_h2[i];
            3'd1:    r[i] = ~m_h2[i];
            3'd2:    r[i] = m_pos[i];
            3'd3:    r[i] = m_neg[i];
            3'd4:    r[i] = m_both[i];
            default: r[i] = 1'b0;
         endcase
         r[i] = r[i] & m_cfg[i][3];
      end
      return r;
   endfunction

   function automatic logic [31:0] model_read(input logic [7:0] addr);
      gpio_pkg::pin_vec_t in_en;
      for (int i = 0; i < gpio_pkg::IO_NUM; i++)
         in_en[i] = m_cfg[i][1];
      if (addr < gpio_pkg::ADDR_CFG_LIMIT)
         return {24'h0, m_cfg[addr[6:2]]};
      if (addr == gpio_pkg::ADDR_INT_STAT)
         return m_stat;
      if (addr == gpio_pkg::ADDR_GPIN)
         return m_h2 & in_en;
      if (addr == gpio_pkg::ADDR_GPOUT)
         return m_gpout;
      return 32'd0;
   endfunction

   // ------------------------------
   // reference model
   // ------------------------------
   always @(posedge PCLK or negedge aresetn)
   begin
      logic               wr;
      logic               stat_wr;
      gpio_pkg::pin_vec_t clr;
      gpio_pkg::pin_vec_t en;
      gpio_pkg::pin_vec_t rise;
      gpio_pkg::pin_vec_t fall;
      if (!aresetn)
      begin
         for (int i = 0; i < gpio_pkg::IO_NUM; i++)
            m_cfg[i] <= 8'h00;
         m_gpout <= '0;
         m_h0    <= '0;
         m_h1    <= '0;
         m_h2    <= '0;
         m_pos   <= '0;
         m_neg   <= '0;
         m_both  <= '0;
         m_stat  <= '0;
      end
      else
      begin
         wr      = psel & penable & pwrite;
         stat_wr = wr && (paddr == gpio_pkg::ADDR_INT_STAT);
         clr     = stat_wr ? pwdata : '0;
         for (int i = 0; i < gpio_pkg::IO_NUM; i++)
            en[i] = m_cfg[i][3];
         // edge seen as the newest history stage moves into the oldest
         rise = m_h1 & ~m_h2;
         fall = ~m_h1 & m_h2;
         m_h0   <= gpio_in;
         m_h1   <= m_h0;
         m_h2   <= m_h1;
         m_pos  <= en & (rise | (m_pos & ~clr));
         m_neg  <= en & (fall | (m_neg & ~clr));
         m_both <= en & (rise | fall | (m_both & ~clr));
         m_stat <= stat_wr ? (m_stat & ~clr) : model_int();
         if (wr && (paddr < gpio_pkg::ADDR_CFG_LIMIT))
            m_cfg[paddr[6:2]] <= pwdata[7:0];
         if (wr && (paddr == gpio_pkg::ADDR_GPOUT))
            m_gpout <= pwdata;
      end
   end

   // outputs against the model on every cycle out of reset
   always @(negedge PCLK)
   begin
      gpio_pkg::pin_vec_t exp_out;
      gpio_pkg::pin_vec_t exp_oe;
      if (aresetn)
      begin
         for (int i = 0; i < gpio_pkg::IO_NUM; i++)
         begin
            exp_out[i] = m_gpout[i] & m_cfg[i][0];
            exp_oe[i]  = m_cfg[i][2] & m_cfg[i][0];
         end
         check_val("GPIO_OUT", gpio_out, exp_out);
         check_val("GPIO_OE", gpio_oe, exp_oe);
         check_val("INT", int_vec, model_int());
         check_val("INT_OR", 32'(int_or), 32'(|model_int()));
      end
   end

   // ------------------------------
   // APB and pin tasks
   // ------------------------------
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      int n;
      @(posedge PCLK);
      psel   <= 1'b1;
      pwrite <= 1'b1;
      paddr  <= addr;
      pwdata <= data;
      @(posedge PCLK);
      penable <= 1'b1;
      n = 0;
      @(negedge PCLK);
      while (!pready && n < WAIT_LIMIT)
      begin
         @(negedge PCLK);
         n++;
      end
      if (!pready)
      begin
         $display("APB write to %h timed out waiting for PREADY at %0t", addr, $time);
         errors++;
      end
      @(posedge PCLK);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   // read data is sampled mid-cycle in the access phase
   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      int n;
      @(posedge PCLK);
      psel   <= 1'b1;
      pwrite <= 1'b0;
      paddr  <= addr;
      @(posedge PCLK);
      penable <= 1'b1;
      n = 0;
      data = '0;
      @(negedge PCLK);
      while (!pready && n < WAIT_LIMIT)
      begin
         @(negedge PCLK);
         n++;
      end
      if (!pready)
      begin
         $display("APB read of %h timed out waiting for PREADY at %0t", addr, $time);
         errors++;
      end
      else
      begin
         data = prdata;
         check_val($sformatf("PRDATA[%h]", addr), prdata, model_read(addr));
         check_val("PSLVERR", 32'(pslverr), 32'd0);
      end
      @(posedge PCLK);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic drive_pins(input gpio_pkg::pin_vec_t v);
      @(posedge PCLK);
      gpio_in <= v;
   endtask

   // ------------------------------
   // stimulus
   // ------------------------------
   initial
   begin
      logic [31:0]        v;
      logic [31:0]        m;
      logic [31:0]        d;
      logic [7:0]         a;
      logic [7:0]         b;
      logic [7:0]         cfg_s [gpio_pkg::IO_NUM];
      gpio_pkg::pin_vec_t gpout_s;
      gpio_pkg::pin_vec_t in_en_s;
      gpio_pkg::pin_vec_t ien_s;
      gpio_pkg::pin_vec_t low_s;
      gpio_pkg::pin_vec_t edge_s;
      gpio_pkg::pin_vec_t lvl_s;
      gpio_pkg::pin_vec_t pins;
      gpio_pkg::pin_vec_t exp;
      gpio_pkg::pin_vec_t oe_exp;
      lfsr     = 32'd53;
      errors   = 0;
      n_checks = 0;
      aresetn <= 1'b0;
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= '0;
      pwdata  <= '0;
      gpio_in <= '0;
      repeat (3) @(posedge PCLK);
      aresetn <= 1'b1;

      // everything reads zero out of reset
      @(negedge PCLK);
      check_val("GPIO_OUT after reset", gpio_out, 32'd0);
      check_val("GPIO_OE after reset", gpio_oe, 32'd0);
      check_val("INT after reset", int_vec, 32'd0);
      check_val("INT_OR after reset", 32'(int_or), 32'd0);
      for (int i = 0; i < gpio_pkg::IO_NUM; i++)
      begin
         apb_read(8'(i * 4), d);
         check_val("cfg after reset", d, 32'd0);
      end
      apb_read(gpio_pkg::ADDR_INT_STAT, d);
      check_val("INT_STAT after reset", d, 32'd0);
      apb_read(gpio_pkg::ADDR_GPIN, d);
      check_val("GPIN after reset", d, 32'd0);
      apb_read(gpio_pkg::ADDR_GPOUT, d);
      check_val("GPOUT after reset", d, 32'd0);

      // random config bytes and output value
      for (int i = 0; i < gpio_pkg::IO_NUM; i++)
      begin
         take_bits(8, v);
         cfg_s[i] = v[7:0];
         apb_write(8'(i * 4), v);
      end
      take_bits(32, v);
      gpout_s = v;
      apb_write(gpio_pkg::ADDR_GPOUT, v);
      @(negedge PCLK);
      for (int i = 0; i < gpio_pkg::IO_NUM; i++)
      begin
         exp[i]     = gpout_s[i] & cfg_s[i][0];
         oe_exp[i]  = cfg_s[i][2] & cfg_s[i][0];
         in_en_s[i] = cfg_s[i][1];
      end
      check_val("GPIO_OUT after write", gpio_out, exp);
      check_val("GPIO_OE after write", gpio_oe, oe_exp);
      for (int i = 0; i < gpio_pkg::IO_NUM; i++)
      begin
         apb_read(8'(i * 4), d);
         check_val("cfg readback", d, {24'h0, cfg_s[i]});
      end
      apb_read(gpio_pkg::ADDR_GPOUT, d);
      check_val("GPOUT readback", d, gpout_s);
      for (int k = 0; k < 8; k++)
      begin
         take_bits(5, v);
         a = 8'h80 | {1'b0, v[4:0], 2'b00};
         if (a != gpio_pkg::ADDR_INT_STAT && a != gpio_pkg::ADDR_GPIN &&
             a != gpio_pkg::ADDR_GPOUT)
         begin
            apb_read(a, d);
            check_val("unmapped read", d, 32'd0);
         end
      end

      // input register follows the pins through the synchronizer
      for (int k = 0; k < 4; k++)
      begin
         take_bits(32, v);
         pins = v;
         drive_pins(pins);
         repeat (3) @(posedge PCLK);
         apb_read(gpio_pkg::ADDR_GPIN, d);
         check_val("GPIN gated", d, pins & in_en_s);
      end

      // level modes with random enables
      for (int i = 0; i < gpio_pkg::IO_NUM; i++)
      begin
         take_bits(2, v);
         low_s[i] = v[0];
         ien_s[i] = v[1];
         b = 8'h02;
         b[7:5] = v[0] ? 3'd1 : 3'd0;
         b[3] = v[1];
         apb_write(8'(i * 4), {24'h0, b});
      end
      for (int k = 0; k < 8; k++)
      begin
         take_bits(32, v);
         pins = v;
         drive_pins(pins);
         repeat (3) @(posedge PCLK);
         @(negedge PCLK);
         exp = ien_s & (pins ^ low_s);
         check_val("INT level", int_vec, exp);
         check_val("INT_OR level", 32'(int_or), 32'(|exp));
      end

      // edge modes mixed with a few level-high pins
      for (int i = 0; i < gpio_pkg::IO_NUM; i++)
      begin
         take_bits(2, v);
         take_bits(2, m);
         b = 8'h02;
         case (v[1:0])
            2'd0:    b[7:5] = 3'd2;
            2'd1:    b[7:5] = 3'd3;
            2'd2:    b[7:5] = 3'd4;
            default: b[7:5] = 3'd0;
         endcase
         b[3] = m[0] | m[1];
         edge_s[i] = b[3] && (v[1:0] != 2'd3);
         lvl_s[i]  = b[3] && (v[1:0] == 2'd3);
         apb_write(8'(i * 4), {24'h0, b});
      end
      for (int k = 0; k < 12; k++)
      begin
         take_bits(32, v);
         pins = pins ^ v;
         drive_pins(pins);
         take_bits(2, v);
         repeat (32'(v[1:0]) + 1) @(posedge PCLK);
         apb_read(gpio_pkg::ADDR_INT_STAT, d);
         if (k % 3 == 2)
         begin
            take_bits(32, m);
            if (m == 32'd0)
               m = 32'd1;
            apb_write(gpio_pkg::ADDR_INT_STAT, m);
         end
      end

      // edge bits must stay low after a clear while the pins are steady
      repeat (4) @(posedge PCLK);
      take_bits(32, m);
      m = m | 32'd1;
      apb_write(gpio_pkg::ADDR_INT_STAT, m);
      repeat (2) @(posedge PCLK);
      @(negedge PCLK);
      check_val("INT edge bits after clear", int_vec & m & edge_s, 32'd0);
      check_val("INT level bits after clear", int_vec & lvl_s, pins & lvl_s);
      apb_read(gpio_pkg::ADDR_INT_STAT, d);
      check_val("INT_STAT edge bits after clear", d & m & edge_s, 32'd0);
      check_val("INT_STAT level bits after clear", d & lvl_s, pins & lvl_s);

      repeat (2) @(posedge PCLK);
      $display("tb_gpio: %0d checks, %0d errors", n_checks, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// File: verilog.f
design/gpio_pkg.sv
design/gpio_apb_regs.sv
design/gpio_in_sync.sv
design/gpio_edge_detect.sv
design/gpio_irq_gen.sv
design/gpio_top.sv
tests/tb_gpio.sv

// File: Makefile
# Verilator simulation of the APB GPIO block

VERILATOR ?= verilator
TOP       ?= tb_gpio
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the log holds the pass line
run: compile
	./$(SIM) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
